// File: all.f
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_stage_if.sv
rtl/fetch_address_gen.sv
rtl/fetch_tlb_lookup.sv
rtl/i_cache.sv
rtl/fetch_fsm.sv
rtl/fetch_top.sv
dv/fetch_tb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module fetch_tb

output=$(./obj_dir/Vfetch_tb)
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: dv/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_tb;

  // One stimulus row: TLB write, CS limit, start address, entries to take
  // exc is 0 for none, 1 for protection fault, 2 for page fault
  typedef struct {
    logic [2:0]  idx;
    logic [19:0] vpn;
    logic [2:0]  pfn;
    logic        valid;
    logic        present;
    logic [31:0] limit;
    logic [31:0] eip;
    int          count;
    int          exc;
    logic        bp;
  } row_t;

  localparam int NUM_ROWS = 8;

  logic clk;
  logic reset;
  logic redirect;
  logic [31:0] redirect_eip;
  logic tlb_we;
  logic [2:0] tlb_index;
  logic [19:0] tlb_vpn;
  logic [2:0] tlb_pfn;
  logic tlb_valid;
  logic tlb_present;
  logic [31:0] cs_limit;
  logic ic_miss;
  logic [14:0] ic_miss_addr;
  logic fill_valid;
  logic [`FETCH_LINE_W-1:0] fill_data;
  logic de_p;
  logic de_valid;
  logic [`FETCH_CHUNK_W-1:0] de_bytes;
  logic [31:0] de_eip;
  logic de_prot_exc;
  logic de_page_fault;

  row_t rows [NUM_ROWS];
  integer seed = 32'haf7c;
  int errors = 0;
  int checks = 0;
  int miss_count = 0;
  logic timed_out = 1'b0;

  // Reference copy of the cache directory, kept from misses and fills
  logic [5:0] tag_model [16];
  logic [15:0] valid_model = '0;

  fetch_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // Byte at physical address p is p[7:0] xor p[14:8]
  function automatic logic [7:0] mem_byte(input logic [14:0] p);
    return p[7:0] ^ {1'b0, p[14:8]};
  endfunction

  function automatic logic [`FETCH_LINE_W-1:0] make_line(input logic [14:0] base);
    logic [`FETCH_LINE_W-1:0] l;
    for (int k = 0; k < 32; k++) begin
      l[k*8 +: 8] = mem_byte(base + 15'(k));
    end
    return l;
  endfunction

  function automatic logic [127:0] make_chunk(input logic [14:0] base);
    logic [127:0] c;
    for (int k = 0; k < 16; k++) begin
      c[k*8 +: 8] = mem_byte(base + 15'(k));
    end
    return c;
  endfunction

  task automatic set_row(input int r, input logic [2:0] idx, input logic [19:0] vpn,
                         input logic [2:0] pfn, input logic present,
                         input logic [31:0] limit, input logic [31:0] eip,
                         input int count, input int exc, input logic bp);
    rows[r] = '{idx, vpn, pfn, 1'b1, present, limit, eip, count, exc, bp};
  endtask

  task automatic fill_table();
    // Cold sequential run, misses on every line
    set_row(0, 3'd0, 20'h00001, 3'd3, 1'b1, 32'hffff_ffff, 32'h0000_1000, 12, 0, 1'b0);
    // Unaligned start under back-pressure, partly cached
    set_row(1, 3'd0, 20'h00001, 3'd3, 1'b1, 32'hffff_ffff, 32'h0000_1048, 10, 0, 1'b1);
    // Re-fetch of cached lines
    set_row(2, 3'd0, 20'h00001, 3'd3, 1'b1, 32'hffff_ffff, 32'h0000_1000, 4, 0, 1'b0);
    // Window crosses the CS limit
    set_row(3, 3'd1, 20'h00040, 3'd5, 1'b1, 32'h0004_0fff, 32'h0004_0ff8, 1, 1, 1'b0);
    // Mapped but not present
    set_row(4, 3'd2, 20'h00077, 3'd6, 1'b0, 32'hffff_ffff, 32'h0007_7010, 1, 2, 1'b0);
    // Page not in the TLB at all
    set_row(5, 3'd3, 20'h00123, 3'd1, 1'b1, 32'hffff_ffff, 32'h0040_0020, 1, 2, 1'b0);
    set_row(6, 3'd3, 20'h00123, 3'd1, 1'b1, 32'hffff_ffff, 32'h0012_3100, 16, 0, 1'b1);
    // Runs right up to the limit
    set_row(7, 3'd1, 20'h00040, 3'd5, 1'b1, 32'h0004_0fff, 32'h0004_0f00, 16, 0, 1'b0);
  endtask

  // Memory side: answer each miss after 1 to 6 cycles
  initial begin
    logic [14:0] addr;
    int delay;
    forever begin
      @(negedge clk);
      if (ic_miss && !reset) begin
        addr = ic_miss_addr;
        miss_count++;
        if (addr[4:0] != 5'd0) begin
          errors++;
          $display("Miss address %h at time %0t is not line aligned", addr, $time);
        end
        if (valid_model[addr[8:5]] && tag_model[addr[8:5]] == addr[14:9]) begin
          errors++;
          $display("Miss at time %0t for line %h which is already cached", $time, addr);
        end
        delay = 1 + ({$random(seed)} % 6);
        repeat (delay) @(posedge clk);
        #2;
        fill_valid = 1'b1;
        fill_data  = make_line(addr);
        @(posedge clk);
        #2;
        fill_valid = 1'b0;
        tag_model[addr[8:5]]   = addr[14:9];
        valid_model[addr[8:5]] = 1'b1;
      end
    end
  end

  task automatic write_tlb(input int r);
    @(posedge clk);
    #2;
    tlb_we      = 1'b1;
    tlb_index   = rows[r].idx;
    tlb_vpn     = rows[r].vpn;
    tlb_pfn     = rows[r].pfn;
    tlb_valid   = rows[r].valid;
    tlb_present = rows[r].present;
    cs_limit    = rows[r].limit;
    @(posedge clk);
    #2;
    tlb_we = 1'b0;
  endtask

  task automatic do_redirect(input int r);
    @(posedge clk);
    #2;
    redirect     = 1'b1;
    redirect_eip = rows[r].eip;
    @(posedge clk);
    #2;
    redirect   = 1'b0;
    miss_count = 0;
  endtask

  // Take entries from the decode latch and compare with the expected stream
  task automatic collect(input int r);
    logic [31:0] exp_eip;
    logic [14:0] line;
    int got;
    int idle;
    exp_eip = rows[r].eip;
    got = 0;
    idle = 0;
    while (got < rows[r].count && !timed_out) begin
      @(negedge clk);
      if (de_valid && de_p) begin
        check("de_eip", 128'(de_eip), 128'(exp_eip));
        check("de_prot_exc", 128'(de_prot_exc), 128'(rows[r].exc == 1));
        check("de_page_fault", 128'(de_page_fault), 128'(rows[r].exc == 2));
        if (rows[r].exc == 0) begin
          line = {rows[r].pfn, exp_eip[11:5], 5'b0};
          if (!(valid_model[line[8:5]] && tag_model[line[8:5]] == line[14:9])) begin
            errors++;
            $display("Entry %h at time %0t used line %h that was never filled",
                     exp_eip, $time, line);
          end
          check("de_bytes", de_bytes, make_chunk({rows[r].pfn, exp_eip[11:4], 4'b0}));
        end
        got++;
        idle = 0;
        exp_eip = {exp_eip[31:4] + 28'd1, 4'b0000};
      end else begin
        idle++;
        if (idle > 200) begin
          errors++;
          timed_out = 1'b1;
          $display("Timed out in row %0d waiting for decode entry %0d", r, got);
        end
      end
      @(posedge clk);
      #2;
      de_p = rows[r].bp ? 1'($random(seed)) : 1'b1;
    end
    de_p = 1'b1;
  endtask

  // After a fault the latch must stay empty until the next redirect
  task automatic check_halted(input int r);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (de_valid) begin
        errors++;
        $display("Decode entry %h appeared after a fault at time %0t", de_eip, $time);
      end
    end
    if (rows[r].exc == 2) begin
      check("miss_count", 128'(miss_count), 128'd0);
    end
  endtask

  initial begin
    reset        = 1'b1;
    redirect     = 1'b0;
    redirect_eip = '0;
    tlb_we       = 1'b0;
    tlb_index    = '0;
    tlb_vpn      = '0;
    tlb_pfn      = '0;
    tlb_valid    = 1'b0;
    tlb_present  = 1'b0;
    cs_limit     = '0;
    fill_valid   = 1'b0;
    fill_data    = '0;
    de_p         = 1'b1;
    fill_table();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      write_tlb(r);
      do_redirect(r);
      collect(r);
      if (timed_out) begin
        break;
      end
      if (rows[r].exc != 0) begin
        check_halted(r);
      end
    end
    $display("errors=%0d checks=%0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
  input  logic                clk,
  input  logic                reset,
  // Redirect from the back end
  input  logic                redirect,
  input  fetch_pkg::eip_t     redirect_eip,
  // TLB write port
  input  logic                tlb_we,
  input  fetch_pkg::tlb_idx_t tlb_index,
  input  fetch_pkg::vpn_t     tlb_vpn,
  input  fetch_pkg::pfn_t     tlb_pfn,
  input  logic                tlb_valid,
  input  logic                tlb_present,
  input  fetch_pkg::eip_t     cs_limit,
  // Memory side
  output logic                ic_miss,
  output fetch_pkg::paddr_t   ic_miss_addr,
  input  logic                fill_valid,
  input  fetch_pkg::line_t    fill_data,
  // Decode side
  input  logic                de_p,
  output logic                de_valid,
  output fetch_pkg::chunk_t   de_bytes,
  output fetch_pkg::eip_t     de_eip,
  output logic                de_prot_exc,
  output logic                de_page_fault
);
  import fetch_pkg::*;

  // Stage-to-stage requests
  fetch_stage_if ag_req ();
  fetch_stage_if tl_req ();

  // Common hold for both upstream stages
  logic      stall;
  logic      ic_hit;
  chunk_t    ic_chunk;
  ic_index_t ic_index;
  ic_tag_t   ic_tag;
  logic      ic_half;

  // Cache address from the translated request
  assign ic_index = tl_req.eip[`FETCH_PAGE_OFF_W-4:`FETCH_LINE_OFF_W];
  assign ic_tag   = {tl_req.pfn, tl_req.eip[`FETCH_PAGE_OFF_W-1:`FETCH_PAGE_OFF_W-3]};
  assign ic_half  = tl_req.eip[`FETCH_LINE_OFF_W-1];

  fetch_address_gen u_f_address_gen (
    .clk          (clk),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_eip (redirect_eip),
    .stall        (stall),
    .req          (ag_req.src)
  );

  fetch_tlb_lookup u_f_tlb_lookup (
    .clk         (clk),
    .reset       (reset),
    .redirect    (redirect),
    .stall       (stall),
    .tlb_we      (tlb_we),
    .tlb_index   (tlb_index),
    .tlb_vpn     (tlb_vpn),
    .tlb_pfn     (tlb_pfn),
    .tlb_valid   (tlb_valid),
    .tlb_present (tlb_present),
    .cs_limit    (cs_limit),
    .req_in      (ag_req.dst),
    .req_out     (tl_req.src)
  );

  i_cache u_i_cache (
    .clk        (clk),
    .reset      (reset),
    .index      (ic_index),
    .tag        (ic_tag),
    .half       (ic_half),
    .fill_valid (fill_valid),
    .fill_data  (fill_data),
    .hit        (ic_hit),
    .rd_chunk   (ic_chunk)
  );

  fetch_fsm u_f_fsm (
    .clk           (clk),
    .reset         (reset),
    .redirect      (redirect),
    .req_in        (tl_req.dst),
    .de_p          (de_p),
    .hit           (ic_hit),
    .rd_chunk      (ic_chunk),
    .ic_miss       (ic_miss),
    .ic_miss_addr  (ic_miss_addr),
    .stall         (stall),
    .de_valid      (de_valid),
    .de_bytes      (de_bytes),
    .de_eip        (de_eip),
    .de_prot_exc   (de_prot_exc),
    .de_page_fault (de_page_fault)
  );

endmodule

// File: rtl/fetch_fsm.sv
`timescale 1ns/1ns

module fetch_fsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              redirect,
  fetch_stage_if.dst        req_in,
  input  logic              de_p,
  input  logic              hit,
  input  fetch_pkg::chunk_t rd_chunk,
  output logic              ic_miss,
  output fetch_pkg::paddr_t ic_miss_addr,
  output logic              stall,
  output logic              de_valid,
  output fetch_pkg::chunk_t de_bytes,
  output fetch_pkg::eip_t   de_eip,
  output logic              de_prot_exc,
  output logic              de_page_fault
);
  import fetch_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;

  logic req_exc;
  logic latch_free;
  logic load_de;
  logic miss_start;

  // Either fault goes to decode instead of cache data
  assign req_exc = req_in.prot_exc || req_in.page_fault;

  // Latch empty, or decode takes its entry this cycle
  assign latch_free = !de_valid || de_p;

  // Redirect squashes the request sitting in this stage
  assign load_de = (state_q == RUN) && req_in.valid && !redirect
                   && latch_free && (req_exc || hit);

  // Miss goes out whether or not the latch is free
  assign miss_start = (state_q == RUN) && req_in.valid && !redirect
                      && !req_exc && !hit;

  always_comb begin
    state_d = state_q;
    stall   = 1'b1;
    case (state_q)
      RUN: begin
        // Hold upstream unless this request is consumed
        stall = req_in.valid && !(latch_free && (req_exc || hit));
        if (load_de && req_exc) begin
          state_d = HALT_EXC;
        end else if (miss_start) begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT: begin
        // Request held in place, leave once the fill lands
        // Also covers a redirect during the miss
        if (hit) begin
          state_d = RUN;
        end
      end
      HALT_EXC: begin
        if (redirect) begin
          state_d = RUN;
        end
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // One-cycle miss pulse on entry to MISS_WAIT
  always_ff @(posedge clk) begin
    if (reset) begin
      ic_miss <= 1'b0;
    end else begin
      ic_miss <= miss_start;
    end
  end

  // Line-aligned physical address for the memory side
  always_ff @(posedge clk) begin
    if (miss_start) begin
      ic_miss_addr <= {req_in.pfn,
                       req_in.eip[`FETCH_PAGE_OFF_W-1:`FETCH_LINE_OFF_W],
                       {`FETCH_LINE_OFF_W{1'b0}}};
    end
  end

  // Decode latch valid
  always_ff @(posedge clk) begin
    if (reset) begin
      de_valid <= 1'b0;
    end else if (redirect) begin
      de_valid <= 1'b0;
    end else if (load_de) begin
      de_valid <= 1'b1;
    end else if (de_p) begin
      de_valid <= 1'b0;
    end
  end

  // Decode latch payload
  // Faulting entries carry no bytes
  always_ff @(posedge clk) begin
    if (load_de) begin
      de_eip        <= req_in.eip;
      de_bytes      <= req_exc ? '0 : rd_chunk;
      de_prot_exc   <= req_in.prot_exc;
      de_page_fault <= req_in.page_fault;
    end
  end

  // Miss request is a pulse, never a level
  a_miss_pulse : assert property (
    @(posedge clk) disable iff (reset)
    ic_miss |=> !ic_miss
  );

endmodule

// File: rtl/i_cache.sv
`timescale 1ns/1ns

module i_cache (
  input  logic                clk,
  input  logic                reset,
  input  fetch_pkg::ic_index_t index,
  input  fetch_pkg::ic_tag_t  tag,
  input  logic                half,
  input  logic                fill_valid,
  input  fetch_pkg::line_t    fill_data,
  output logic                hit,
  output fetch_pkg::chunk_t   rd_chunk
);
  import fetch_pkg::*;

  // Tag and data arrays, one line per set
  ic_tag_t tag_q [`FETCH_IC_SETS];
  line_t   data_q [`FETCH_IC_SETS];
  // Per-set valid
  logic [`FETCH_IC_SETS-1:0] valid_q;

  // Line at the current index
  line_t   rd_line;
  ic_tag_t rd_tag;

  // Fill writes tag and data at the presented index
  // Index and tag are held by the stall during the miss
  always_ff @(posedge clk) begin
    if (fill_valid) begin
      tag_q[index]  <= tag;
      data_q[index] <= fill_data;
    end
  end

  // Cold cache after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (fill_valid) begin
      valid_q[index] <= 1'b1;
    end
  end

  // Asynchronous read
  assign rd_line = data_q[index];
  assign rd_tag  = tag_q[index];

  assign hit = valid_q[index] && (rd_tag == tag);

  // EIP bit 4 picks the upper or lower 16 bytes
  assign rd_chunk = half ? rd_line[`FETCH_CHUNK_W +: `FETCH_CHUNK_W]
                         : rd_line[0 +: `FETCH_CHUNK_W];

  // Fetch control holds the request through the fill,
  // so the same address hits right after
  a_fill_then_hit : assert property (
    @(posedge clk) disable iff (reset)
    fill_valid |=> hit
  );

endmodule

// File: rtl/fetch_tlb_lookup.sv
`timescale 1ns/1ns

module fetch_tlb_lookup (
  input  logic               clk,
  input  logic               reset,
  input  logic               redirect,
  input  logic               stall,
  input  logic               tlb_we,
  input  fetch_pkg::tlb_idx_t tlb_index,
  input  fetch_pkg::vpn_t    tlb_vpn,
  input  fetch_pkg::pfn_t    tlb_pfn,
  input  logic               tlb_valid,
  input  logic               tlb_present,
  input  fetch_pkg::eip_t    cs_limit,
  fetch_stage_if.dst         req_in,
  fetch_stage_if.src         req_out
);
  import fetch_pkg::*;

  // TLB entries
  vpn_t tlb_vpn_q [`FETCH_TLB_ENTRIES];
  pfn_t tlb_pfn_q [`FETCH_TLB_ENTRIES];
  logic [`FETCH_TLB_ENTRIES-1:0] tlb_present_q;
  logic [`FETCH_TLB_ENTRIES-1:0] tlb_valid_q;

  // Lookup results
  vpn_t req_vpn;
  logic [`FETCH_TLB_ENTRIES-1:0] match;
  pfn_t hit_pfn;
  logic hit_present;
  logic page_fault;
  // One extra bit so the window end cannot wrap
  logic [`FETCH_EIP_W:0] win_end;
  logic prot_exc;

  // Write port
  always_ff @(posedge clk) begin
    if (tlb_we) begin
      tlb_vpn_q[tlb_index]     <= tlb_vpn;
      tlb_pfn_q[tlb_index]     <= tlb_pfn;
      tlb_present_q[tlb_index] <= tlb_present;
    end
  end

  // Entry valid bits, empty TLB out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      tlb_valid_q <= '0;
    end else if (tlb_we) begin
      tlb_valid_q[tlb_index] <= tlb_valid;
    end
  end

  assign req_vpn = req_in.eip[`FETCH_EIP_W-1:`FETCH_PAGE_OFF_W];

  // Compare against every entry at once
  // At most one match, so OR-ing the fields is a mux
  always_comb begin
    match       = '0;
    hit_pfn     = '0;
    hit_present = 1'b0;
    for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
      if (tlb_valid_q[i] && (tlb_vpn_q[i] == req_vpn)) begin
        match[i]    = 1'b1;
        hit_pfn     = hit_pfn | tlb_pfn_q[i];
        hit_present = hit_present | tlb_present_q[i];
      end
    end
  end

  // Miss, or mapped but swapped out
  assign page_fault = !(|match) || !hit_present;

  // Last byte of the 16-byte window against the CS limit
  assign win_end  = {1'b0, req_in.eip} + 33'd15;
  assign prot_exc = win_end > {1'b0, cs_limit};

  // Stage-two request valid
  always_ff @(posedge clk) begin
    if (reset) begin
      req_out.valid <= 1'b0;
    end else if (redirect) begin
      req_out.valid <= 1'b0;
    end else if (!stall) begin
      req_out.valid <= req_in.valid;
    end
  end

  // Stage-two payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      req_out.eip        <= req_in.eip;
      req_out.pfn        <= hit_pfn;
      req_out.prot_exc   <= prot_exc;
      req_out.page_fault <= page_fault;
    end
  end

  // Software must never map one page twice
  a_tlb_onehot : assert property (
    @(posedge clk) disable iff (reset)
    req_in.valid |-> $onehot0(match)
  );

endmodule

// File: rtl/fetch_address_gen.sv
`timescale 1ns/1ns

module fetch_address_gen (
  input  logic           clk,
  input  logic           reset,
  input  logic           redirect,
  input  fetch_pkg::eip_t redirect_eip,
  input  logic           stall,
  fetch_stage_if.src     req
);
  import fetch_pkg::*;

  // Set by the first redirect, never cleared except by reset
  logic started_q;
  eip_t eip_q;
  eip_t eip_next;

  // Next 16-byte boundary
  assign eip_next = {eip_q[`FETCH_EIP_W-1:4] + 28'd1, 4'b0000};

  // EIP register
  // Redirect wins over stall
  always_ff @(posedge clk) begin
    if (reset) begin
      started_q <= 1'b0;
      eip_q     <= '0;
    end else if (redirect) begin
      started_q <= 1'b1;
      eip_q     <= redirect_eip;
    end else if (started_q && !stall) begin
      eip_q <= eip_next;
    end
  end

  // Stage-one request valid
  // Squashed by redirect, held while stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      req.valid <= 1'b0;
    end else if (redirect) begin
      req.valid <= 1'b0;
    end else if (!stall) begin
      req.valid <= started_q;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      req.eip <= eip_q;
    end
  end

  // Nothing translated or checked yet
  assign req.pfn        = '0;
  assign req.prot_exc   = 1'b0;
  assign req.page_fault = 1'b0;

  // Fetch stays quiet until software gives a start address
  a_no_req_before_redirect : assert property (
    @(posedge clk) disable iff (reset)
    !started_q |-> !req.valid
  );

endmodule

// File: rtl/fetch_stage_if.sv
`timescale 1ns/1ns

interface fetch_stage_if;
  import fetch_pkg::*;

  // Request occupies this stage
  logic valid;
  // Instruction pointer of the 16-byte window
  eip_t eip;
  // Translated frame, zero before the TLB stage
  pfn_t pfn;
  // Fetch window crosses the CS limit
  logic prot_exc;
  // No valid TLB entry or page not present
  logic page_fault;

  // Stage that owns the register
  modport src (
    output valid,
    output eip,
    output pfn,
    output prot_exc,
    output page_fault
  );

  // Next stage down the pipe
  modport dst (
    input valid,
    input eip,
    input pfn,
    input prot_exc,
    input page_fault
  );

endinterface

// File: rtl/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

  // Addresses
  typedef logic [`FETCH_EIP_W-1:0] eip_t;
  typedef logic [`FETCH_VPN_W-1:0] vpn_t;
  typedef logic [`FETCH_PFN_W-1:0] pfn_t;
  typedef logic [`FETCH_PADDR_W-1:0] paddr_t;

  // Cache data
  typedef logic [`FETCH_LINE_W-1:0] line_t;
  typedef logic [`FETCH_CHUNK_W-1:0] chunk_t;

  // Cache addressing
  typedef logic [$clog2(`FETCH_IC_SETS)-1:0] ic_index_t;
  // Frame number followed by paddr bits 11..9
  typedef logic [`FETCH_TAG_W-1:0] ic_tag_t;

  // TLB entry select on the write port
  typedef logic [$clog2(`FETCH_TLB_ENTRIES)-1:0] tlb_idx_t;

  // Fetch control states
  typedef enum logic [1:0] {
    // Normal flow, one request per cycle
    RUN,
    // Line fill outstanding
    MISS_WAIT,
    // Exception handed to decode, wait for redirect
    HALT_EXC
  } fetch_state_t;

endpackage

// File: include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction pointer and linear address
`define FETCH_EIP_W 32

// One cache line, and the half of it that a fetch returns
`define FETCH_LINE_W 256
`define FETCH_CHUNK_W 128
// Byte offset bits inside a 32-byte line
`define FETCH_LINE_OFF_W 5

// 4 KB pages
`define FETCH_PAGE_OFF_W 12
`define FETCH_VPN_W 20
`define FETCH_PFN_W 3
// Frame number on top of the page offset
`define FETCH_PADDR_W 15

// Fully associative TLB
`define FETCH_TLB_ENTRIES 8

// Direct-mapped I-cache, tag is pfn plus paddr[11:9]
`define FETCH_IC_SETS 16
`define FETCH_TAG_W 6

`endif
